// File: tb.f
+incdir+include
source/mnist_pad_pkg.sv
source/ps2_receiver.sv
source/cursor_grid.sv
source/seven_segment_display.sv
source/drawing_pad_top.sv
verif/drawing_pad_tb.sv

// File: Bender.yml
package:
  name: mnist_drawing_pad

sources:
  - include_dirs:
      - include
    files:
      - source/mnist_pad_pkg.sv
      - source/ps2_receiver.sv
      - source/cursor_grid.sv
      - source/seven_segment_display.sv
      - source/drawing_pad_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/drawing_pad_tb.sv

// File: verif/drawing_pad_tb.sv
`timescale 1ns/1ps
`include "mnist_pad_defs.svh"

module drawing_pad_tb;

    localparam int half_period  = 20;
    localparam int frame_gap    = 100;
    localparam int cell_count   = `MNIST_PAD_CELL_COUNT;
    localparam int grid_size    = `MNIST_PAD_GRID_SIZE;
    localparam int draw_targets = 5;
    // Edge runs, random keys, bad frames, keys while off, walks to the draw cells
    localparam int max_frames   = 86 + 20 + 2 + 4 + draw_targets * 54;
    localparam int sweep_cycles = 3 * (cell_count + 2);
    localparam int timeout_cycles =
        2 * (max_frames * `MNIST_PAD_FRAME_BITS * 40 + sweep_cycles + 16);

    // Active-low digit patterns, F in the top slice down to 0 in the bottom
    localparam logic [16*7-1:0] seg_patterns = {
        7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
        7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
        7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
        7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
    };

    logic                      clk;
    logic                      reset;
    logic                      on;
    logic                      draw;
    logic                      ps2_clk;
    logic                      ps2_data;
    mnist_pad_pkg::cell_addr_t cell_addr;
    mnist_pad_pkg::segments_t  hex0;
    mnist_pad_pkg::segments_t  hex1;
    mnist_pad_pkg::segments_t  hex2;
    mnist_pad_pkg::segments_t  hex3;
    logic                      cell_value;

    int                        model_x;
    int                        model_y;
    logic [cell_count-1:0]     model_cells;
    int                        checks;
    int                        digit_errors;
    int                        cell_errors;
    int unsigned               seed;

    drawing_pad_top #(
        .move_holdoff (50)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .on         (on),
        .draw       (draw),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .cell_addr  (cell_addr),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .cell_value (cell_value)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Model and checks
    // --------------------

    function automatic logic [6:0] digit_pattern(input int digit);
        return seg_patterns[digit*7 +: 7];
    endfunction

    function automatic mnist_pad_pkg::scan_code_t arrow_for(input int index);
        case (index)
            0:       return mnist_pad_pkg::key_left;
            1:       return mnist_pad_pkg::key_right;
            2:       return mnist_pad_pkg::key_up;
            default: return mnist_pad_pkg::key_down;
        endcase
    endfunction

    // Clamped step, only while the pad is on
    task automatic apply_key_to_model(input mnist_pad_pkg::scan_code_t code);
        if (on) begin
            if (code == mnist_pad_pkg::key_left && model_x > 0) model_x--;
            if (code == mnist_pad_pkg::key_right && model_x < grid_size - 1) model_x++;
            if (code == mnist_pad_pkg::key_up && model_y > 0) model_y--;
            if (code == mnist_pad_pkg::key_down && model_y < grid_size - 1) model_y++;
        end
    endtask

    task automatic compare_digit(input string name, input logic [6:0] expected,
                                 input logic [6:0] actual);
        checks++;
        assert (actual === expected) else begin
            digit_errors++;
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_digits();
        compare_digit("hex0", digit_pattern(model_x % 16), hex0);
        compare_digit("hex1", digit_pattern(model_x / 16), hex1);
        compare_digit("hex2", digit_pattern(model_y % 16), hex2);
        compare_digit("hex3", digit_pattern(model_y / 16), hex3);
    endtask

    // Pipelined read, each address is checked two edges after it is driven
    task automatic sweep_cells();
        for (int i = 0; i < cell_count + 2; i++) begin
            if (i >= 2) begin
                checks++;
                assert (cell_value === model_cells[i-2]) else begin
                    cell_errors++;
                    $display("error at %0t: cell_value at address %0d expected %b, got %b",
                             $time, i - 2, model_cells[i-2], cell_value);
                end
            end
            if (i < cell_count) begin
                cell_addr <= mnist_pad_pkg::cell_addr_t'(i);
            end
            @(posedge clk);
        end
    endtask

    // --------------------
    // PS/2 device side
    // --------------------

    // Start, data LSB first, odd parity, stop
    task automatic send_frame(input mnist_pad_pkg::scan_code_t code, input bit bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, ~^code, code, 1'b0};
        for (int i = 0; i < `MNIST_PAD_FRAME_BITS; i++) begin
            ps2_data <= bits[i];
            repeat (half_period) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (half_period) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
    endtask

    task automatic send_key(input mnist_pad_pkg::scan_code_t code, input bit bad_stop);
        send_frame(code, bad_stop);
        if (!bad_stop) begin
            apply_key_to_model(code);
        end
        repeat (5) @(posedge clk);
        check_digits();
        repeat (frame_gap) @(posedge clk);
    endtask

    task automatic move_cursor_to(input int target_x, input int target_y);
        while (model_x < target_x) send_key(mnist_pad_pkg::key_right, 1'b0);
        while (model_x > target_x) send_key(mnist_pad_pkg::key_left, 1'b0);
        while (model_y < target_y) send_key(mnist_pad_pkg::key_down, 1'b0);
        while (model_y > target_y) send_key(mnist_pad_pkg::key_up, 1'b0);
    endtask

    task automatic draw_at_cursor();
        draw <= 1'b1;
        repeat (3) @(posedge clk);
        draw <= 1'b0;
        @(posedge clk);
        if (on) begin
            model_cells[model_y * grid_size + model_x] = 1'b1;
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        reset        = 1'b1;
        on           = 1'b0;
        draw         = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        cell_addr    = '0;
        model_x      = `MNIST_PAD_HOME;
        model_y      = `MNIST_PAD_HOME;
        model_cells  = '0;
        checks       = 0;
        digit_errors = 0;
        cell_errors  = 0;
        seed         = 32'h4da4_6308;
        void'($urandom(seed));

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        // Home position and an empty grid
        check_digits();
        sweep_cells();

        // Runs into every edge, one clamped key at each
        on <= 1'b1;
        @(posedge clk);
        repeat (15) send_key(mnist_pad_pkg::key_left, 1'b0);
        repeat (28) send_key(mnist_pad_pkg::key_right, 1'b0);
        repeat (15) send_key(mnist_pad_pkg::key_up, 1'b0);
        repeat (28) send_key(mnist_pad_pkg::key_down, 1'b0);

        repeat (20) send_key(arrow_for($urandom % 4), 1'b0);

        // Corrupt frame and a byte that is not an arrow
        send_key(model_x > 0 ? mnist_pad_pkg::key_left : mnist_pad_pkg::key_right, 1'b1);
        send_key(8'h1C, 1'b0);

        // Pad switched off
        on <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            send_key(arrow_for(i), 1'b0);
        end
        draw_at_cursor();
        sweep_cells();

        // Draw at random cells
        on <= 1'b1;
        @(posedge clk);
        repeat (draw_targets) begin
            move_cursor_to($urandom % grid_size, $urandom % grid_size);
            draw_at_cursor();
        end
        sweep_cells();

        $display("checks: %0d, digit errors: %0d, cell errors: %0d",
                 checks, digit_errors, cell_errors);
        if (digit_errors == 0 && cell_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget covers the worst walk to the draw cells
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: source/drawing_pad_top.sv
`timescale 1ns/1ps

module drawing_pad_top #(
    parameter int move_holdoff = 2000000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      on,
    input  logic                      draw,
    input  logic                      ps2_clk,
    input  logic                      ps2_data,
    input  mnist_pad_pkg::cell_addr_t cell_addr,
    output mnist_pad_pkg::segments_t  hex0,
    output mnist_pad_pkg::segments_t  hex1,
    output mnist_pad_pkg::segments_t  hex2,
    output mnist_pad_pkg::segments_t  hex3,
    output logic                      cell_value
);

    logic                      key_valid;
    mnist_pad_pkg::scan_code_t key_code;
    mnist_pad_pkg::coord_t     cursor_x;
    mnist_pad_pkg::coord_t     cursor_y;

    // Keyboard bytes
    ps2_receiver u_ps2_receiver (
        .clk       (clk),
        .reset     (reset),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    // Cursor and drawn cells
    cursor_grid #(
        .move_holdoff (move_holdoff)
    ) u_cursor_grid (
        .clk        (clk),
        .reset      (reset),
        .on         (on),
        .draw       (draw),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .cell_addr  (cell_addr),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .cell_value (cell_value)
    );

    // Position readout
    seven_segment_display u_seven_segment_display (
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3)
    );

endmodule

// File: source/seven_segment_display.sv
`timescale 1ns/1ps

module seven_segment_display (
    input  mnist_pad_pkg::coord_t    cursor_x,
    input  mnist_pad_pkg::coord_t    cursor_y,
    output mnist_pad_pkg::segments_t hex0,
    output mnist_pad_pkg::segments_t hex1,
    output mnist_pad_pkg::segments_t hex2,
    output mnist_pad_pkg::segments_t hex3
);

    // Common anode patterns, bit 6 is segment g
    function automatic mnist_pad_pkg::segments_t hex_to_segments(input logic [3:0] value);
        mnist_pad_pkg::segments_t pattern;
        case (value)
            4'h0: pattern = 7'b1000000;
            4'h1: pattern = 7'b1111001;
            4'h2: pattern = 7'b0100100;
            4'h3: pattern = 7'b0110000;
            4'h4: pattern = 7'b0011001;
            4'h5: pattern = 7'b0010010;
            4'h6: pattern = 7'b0000010;
            4'h7: pattern = 7'b1111000;
            4'h8: pattern = 7'b0000000;
            4'h9: pattern = 7'b0010000;
            4'hA: pattern = 7'b0001000;
            4'hB: pattern = 7'b0000011;
            4'hC: pattern = 7'b1000110;
            4'hD: pattern = 7'b0100001;
            4'hE: pattern = 7'b0000110;
            default: pattern = 7'b0001110;
        endcase
        return pattern;
    endfunction

    // Low nibble and top bit of each coordinate
    assign hex0 = hex_to_segments(cursor_x[3:0]);
    assign hex1 = hex_to_segments({3'b000, cursor_x[4]});
    assign hex2 = hex_to_segments(cursor_y[3:0]);
    assign hex3 = hex_to_segments({3'b000, cursor_y[4]});

endmodule

// File: source/cursor_grid.sv
`timescale 1ns/1ps
`include "mnist_pad_defs.svh"

module cursor_grid #(
    parameter int move_holdoff = 2000000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      on,
    input  logic                      draw,
    input  logic                      key_valid,
    input  mnist_pad_pkg::scan_code_t key_code,
    input  mnist_pad_pkg::cell_addr_t cell_addr,
    output mnist_pad_pkg::coord_t     cursor_x,
    output mnist_pad_pkg::coord_t     cursor_y,
    output logic                      cell_value
);

    localparam int holdoff_width = $clog2(move_holdoff + 1);

    localparam mnist_pad_pkg::coord_t coord_max =
        mnist_pad_pkg::coord_t'(`MNIST_PAD_GRID_SIZE - 1);
    localparam mnist_pad_pkg::coord_t coord_home =
        mnist_pad_pkg::coord_t'(`MNIST_PAD_HOME);

    logic [holdoff_width-1:0]         holdoff_count;
    logic                             key_accept;
    logic                             move_ok;
    mnist_pad_pkg::coord_t            next_x;
    mnist_pad_pkg::coord_t            next_y;

    logic [`MNIST_PAD_CELL_COUNT-1:0] cells;
    mnist_pad_pkg::cell_addr_t        write_addr;

    // --------------------
    // Cursor movement
    // --------------------

    // Only one step per accepted key
    assign key_accept = on && key_valid && (holdoff_count == '0);

    // Step that would leave the grid is dropped
    always_comb begin
        next_x  = cursor_x;
        next_y  = cursor_y;
        move_ok = 1'b0;
        case (key_code)
            mnist_pad_pkg::key_left: begin
                if (cursor_x != '0) begin
                    next_x  = cursor_x - 1'b1;
                    move_ok = 1'b1;
                end
            end
            mnist_pad_pkg::key_right: begin
                if (cursor_x < coord_max) begin
                    next_x  = cursor_x + 1'b1;
                    move_ok = 1'b1;
                end
            end
            mnist_pad_pkg::key_up: begin
                if (cursor_y != '0) begin
                    next_y  = cursor_y - 1'b1;
                    move_ok = 1'b1;
                end
            end
            mnist_pad_pkg::key_down: begin
                if (cursor_y < coord_max) begin
                    next_y  = cursor_y + 1'b1;
                    move_ok = 1'b1;
                end
            end
            default: begin
                move_ok = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor_x      <= coord_home;
            cursor_y      <= coord_home;
            holdoff_count <= '0;
        end else if (key_accept && move_ok) begin
            cursor_x      <= next_x;
            cursor_y      <= next_y;
            holdoff_count <= holdoff_width'(move_holdoff);
        end else if (on && holdoff_count != '0) begin
            // Hold-off freezes along with everything else when off
            holdoff_count <= holdoff_count - 1'b1;
        end
    end

    // --------------------
    // Cell memory
    // --------------------

    assign write_addr = mnist_pad_pkg::cell_addr_t'(cursor_y) *
                        mnist_pad_pkg::cell_addr_t'(`MNIST_PAD_GRID_SIZE) +
                        mnist_pad_pkg::cell_addr_t'(cursor_x);

    // Drawing ignores the hold-off
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cells <= '0;
        end else if (on && draw) begin
            cells[write_addr] <= 1'b1;
        end
    end

    // Registered read, addresses past the grid read as clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cell_value <= 1'b0;
        end else if (cell_addr < mnist_pad_pkg::cell_addr_t'(`MNIST_PAD_CELL_COUNT)) begin
            cell_value <= cells[cell_addr];
        end else begin
            cell_value <= 1'b0;
        end
    end

endmodule

// File: source/ps2_receiver.sv
`timescale 1ns/1ps
`include "mnist_pad_defs.svh"

module ps2_receiver (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ps2_clk,
    input  logic                      ps2_data,
    output logic                      key_valid,
    output mnist_pad_pkg::scan_code_t key_code
);

    localparam int count_width = $clog2(`MNIST_PAD_FRAME_BITS);

    logic [`MNIST_PAD_FILTER_LEN-1:0] filter_reg;
    logic                             ps2_clk_filt;
    logic                             ps2_clk_filt_next;
    logic                             fall_edge;

    mnist_pad_pkg::ps2_rx_state_e     state;
    logic [count_width-1:0]           bits_left;
    logic [`MNIST_PAD_FRAME_BITS-1:0] frame;
    logic                             shift_en;
    logic                             frame_ok;
    logic                             load_code;

    // --------------------
    // Clock filter
    // --------------------

    // Bus idles high, so start the filter there
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            filter_reg   <= '1;
            ps2_clk_filt <= 1'b1;
        end else begin
            filter_reg   <= {ps2_clk, filter_reg[`MNIST_PAD_FILTER_LEN-1:1]};
            ps2_clk_filt <= ps2_clk_filt_next;
        end
    end

    // Level only moves once every sample agrees
    always_comb begin
        if (&filter_reg) begin
            ps2_clk_filt_next = 1'b1;
        end else if (~|filter_reg) begin
            ps2_clk_filt_next = 1'b0;
        end else begin
            ps2_clk_filt_next = ps2_clk_filt;
        end
    end

    assign fall_edge = ps2_clk_filt & ~ps2_clk_filt_next;

    // --------------------
    // Frame FSM
    // --------------------

    // Start bit in idle, the other ten bits in rx_shift
    assign shift_en = fall_edge &&
                      ((state == mnist_pad_pkg::rx_idle && !ps2_data) ||
                       state == mnist_pad_pkg::rx_shift);

    // Parity is not looked at
    assign frame_ok  = !frame[0] && frame[`MNIST_PAD_FRAME_BITS-1];
    assign load_code = (state == mnist_pad_pkg::rx_check) && frame_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= mnist_pad_pkg::rx_idle;
            bits_left <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= load_code;
            case (state)
                mnist_pad_pkg::rx_idle: begin
                    if (shift_en) begin
                        bits_left <= count_width'(`MNIST_PAD_FRAME_BITS - 2);
                        state     <= mnist_pad_pkg::rx_shift;
                    end
                end
                mnist_pad_pkg::rx_shift: begin
                    if (shift_en) begin
                        if (bits_left == '0) begin
                            state <= mnist_pad_pkg::rx_check;
                        end else begin
                            bits_left <= bits_left - 1'b1;
                        end
                    end
                end
                mnist_pad_pkg::rx_check: begin
                    state <= mnist_pad_pkg::rx_idle;
                end
                default: begin
                    state <= mnist_pad_pkg::rx_idle;
                end
            endcase
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (shift_en) begin
            frame <= {ps2_data, frame[`MNIST_PAD_FRAME_BITS-1:1]};
        end
        if (load_code) begin
            key_code <= frame[8:1];
        end
    end

endmodule

// File: source/mnist_pad_pkg.sv
`include "mnist_pad_defs.svh"

package mnist_pad_pkg;

    // --------------------
    // Data types
    // --------------------

    // One cursor coordinate
    typedef logic [`MNIST_PAD_COORD_WIDTH-1:0] coord_t;

    // Flat cell index, row major
    typedef logic [`MNIST_PAD_ADDR_WIDTH-1:0] cell_addr_t;

    // Byte taken from a PS/2 frame
    typedef logic [7:0] scan_code_t;

    // Active low, segment a in bit 0 up to g in bit 6
    typedef logic [6:0] segments_t;

    // --------------------
    // Encodings
    // --------------------

    // Set 2 make codes of the arrow keys
    typedef enum logic [7:0] {
        key_left  = 8'h6B,
        key_right = 8'h74,
        key_up    = 8'h75,
        key_down  = 8'h72
    } arrow_code_e;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_idle,
        rx_shift,
        rx_check
    } ps2_rx_state_e;

endpackage

// File: include/mnist_pad_defs.svh
`ifndef MNIST_PAD_DEFS_SVH
`define MNIST_PAD_DEFS_SVH

// --------------------
// Drawing grid geometry
// --------------------

// Cells per side of the square grid
`define MNIST_PAD_GRID_SIZE 28

// 28 * 28 cells
`define MNIST_PAD_CELL_COUNT 784

// Enough for 0 to 27
`define MNIST_PAD_COORD_WIDTH 5

// Row * 28 + column, up to 783
`define MNIST_PAD_ADDR_WIDTH 10

// Cursor start cell on both axes
`define MNIST_PAD_HOME 14

// --------------------
// PS/2 framing
// --------------------

// Agreeing raw clock samples before the filtered level moves
`define MNIST_PAD_FILTER_LEN 8

// Start, 8 data, parity, stop
`define MNIST_PAD_FRAME_BITS 11

`endif
